// File: tb.f
logic/fetch_pkg.sv
logic/fetch_stage.sv
logic/fetch_hazard_unit.sv
logic/btb_predictor.sv
logic/fetch_frontend.sv
verification/fetch_imem_model.sv
verification/fetch_tb.sv

// File: verification/fetch_tb.sv
// Testbench for the instruction fetch front end
// Clock, reset, redirect, BTB and stall stimulus with a reference PC model
// Concurrent assertions, watchdog and closing summary

module fetch_tb;

    localparam fetch_pkg::word_t DATA_KEY = 32'h13579BDF;
    localparam fetch_pkg::word_t ERR_LO   = 32'h8000_0200;
    localparam fetch_pkg::word_t ERR_HI   = 32'h8000_0208;
    // Sum of all wait_insns counts below
    localparam int PLANNED_INSNS   = 42;
    localparam int CYCLES_PER_INSN = 40;
    localparam int TAG_LSB         = fetch_pkg::BTB_IDX_W + 2;

    logic             CLK;
    logic             nRST;
    fetch_pkg::word_t imem_rdata;
    logic             imem_busy;
    logic             imem_error;
    fetch_pkg::word_t imem_addr;
    logic             imem_ren;
    logic             ex_stall;
    logic             trap_strobe;
    fetch_pkg::word_t trap_pc;
    logic             rollback_strobe;
    fetch_pkg::word_t rollback_pc;
    logic             branch_strobe;
    fetch_pkg::word_t branch_target;
    logic             btb_upd_strobe;
    fetch_pkg::word_t btb_upd_pc;
    fetch_pkg::word_t btb_upd_target;
    logic             btb_upd_taken;
    logic             fe_valid;
    fetch_pkg::word_t fe_instr;
    fetch_pkg::word_t fe_pc;
    fetch_pkg::word_t fe_pc4;
    logic             fe_mal_insn;
    logic             fe_fault_insn;
    fetch_pkg::word_t fe_badaddr;
    logic             fe_prediction;

    // Reference model state
    fetch_pkg::word_t                  exp_pc;
    logic                              fe_new;
    logic                              parked;
    int                                seen;
    int                                errors;
    logic [fetch_pkg::BTB_ENTRIES-1:0] btb_valid;
    fetch_pkg::btb_tag_t               btb_tag    [fetch_pkg::BTB_ENTRIES];
    fetch_pkg::word_t                  btb_target [fetch_pkg::BTB_ENTRIES];
    fetch_pkg::btb_idx_t               exp_idx;
    fetch_pkg::btb_idx_t               upd_idx;
    logic                              exp_hit;
    logic                              exp_mal;
    logic                              exp_fault;
    fetch_pkg::word_t                  exp_instr;
    logic                              any_redirect;

    fetch_frontend i_dut (.*);

    fetch_imem_model i_imem (
        .CLK   (CLK),
        .nRST  (nRST),
        .addr  (imem_addr),
        .ren   (imem_ren),
        .err_lo(ERR_LO),
        .err_hi(ERR_HI),
        .rdata (imem_rdata),
        .busy  (imem_busy),
        .error (imem_error)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // Expected view of the instruction at exp_pc
    assign exp_idx      = exp_pc[TAG_LSB-1:2];
    assign upd_idx      = btb_upd_pc[TAG_LSB-1:2];
    assign exp_hit      = btb_valid[exp_idx] && (btb_tag[exp_idx] == exp_pc[31:TAG_LSB]);
    assign exp_mal      = (exp_pc[1:0] != 2'b00);
    assign exp_fault    = !exp_mal && (exp_pc >= ERR_LO) && (exp_pc < ERR_HI);
    assign exp_instr    = (exp_mal || exp_fault) ? '0 : (exp_pc ^ DATA_KEY);
    assign any_redirect = trap_strobe | rollback_strobe | branch_strobe;

    // Next expected PC, BTB shadow and fault parking
    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            exp_pc    <= fetch_pkg::RESET_PC;
            fe_new    <= 1'b0;
            parked    <= 1'b0;
            seen      <= 0;
            btb_valid <= '0;
        end else begin
            // Register written at this edge unless execute stalls
            fe_new <= !ex_stall;
            if (fe_valid && fe_new) begin
                seen   <= seen + 1;
                exp_pc <= exp_hit ? btb_target[exp_idx] : exp_pc + 32'd4;
                if (exp_fault) begin
                    parked <= 1'b1;
                end
            end
            // Redirects come later in program order than the shown instruction
            if (trap_strobe) begin
                exp_pc <= trap_pc;
                parked <= 1'b0;
            end else if (rollback_strobe) begin
                exp_pc <= rollback_pc;
            end else if (branch_strobe) begin
                exp_pc <= branch_target;
            end
            if (btb_upd_strobe && btb_upd_taken) begin
                btb_valid[upd_idx]  <= 1'b1;
                btb_tag[upd_idx]    <= btb_upd_pc[31:TAG_LSB];
                btb_target[upd_idx] <= btb_upd_target;
            end else if (btb_upd_strobe && btb_tag[upd_idx] == btb_upd_pc[31:TAG_LSB]) begin
                btb_valid[upd_idx] <= 1'b0;
            end
        end
    end

    task automatic note_failure(input string msg);
        errors++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    a_pc: assert property (@(posedge CLK) disable iff (!nRST)
        fe_valid && fe_new |-> fe_pc == exp_pc && fe_pc4 == exp_pc + 32'd4)
        else note_failure("fe_pc or fe_pc4 differs from the expected PC");
    a_instr: assert property (@(posedge CLK) disable iff (!nRST)
        fe_valid && fe_new |-> fe_instr == exp_instr && fe_badaddr == exp_pc)
        else note_failure("fe_instr or fe_badaddr wrong");
    a_exc: assert property (@(posedge CLK) disable iff (!nRST)
        fe_valid && fe_new |-> fe_mal_insn == exp_mal && fe_fault_insn == exp_fault)
        else note_failure("exception flags wrong");
    a_pred: assert property (@(posedge CLK) disable iff (!nRST)
        fe_valid && fe_new |-> fe_prediction == exp_hit)
        else note_failure("fe_prediction wrong");
    a_flush: assert property (@(posedge CLK) disable iff (!nRST)
        any_redirect && !ex_stall |=> !fe_valid)
        else note_failure("no bubble after a redirect");
    a_mal_ren: assert property (@(posedge CLK) disable iff (!nRST)
        imem_addr[1:0] != 2'b00 |-> !imem_ren)
        else note_failure("bus read issued for a misaligned PC");
    a_park: assert property (@(posedge CLK) disable iff (!nRST)
        parked |-> !fe_valid && !imem_ren)
        else note_failure("fetch continued after a bus error");
    a_hold: assert property (@(posedge CLK) disable iff (!nRST)
        ex_stall |=> $stable({fe_valid, fe_instr, fe_pc, fe_pc4, fe_mal_insn,
                              fe_fault_insn, fe_badaddr, fe_prediction}))
        else note_failure("fe_ outputs moved during ex_stall");

    // Returns at a falling edge once n more instructions were shown
    task automatic wait_insns(input int n);
        int target;
        target = seen + n;
        while (seen < target) begin
            @(negedge CLK);
        end
    endtask

    task automatic redirect(input logic do_trap, input logic do_rollback,
                            input logic do_branch, input fetch_pkg::word_t t_pc,
                            input fetch_pkg::word_t r_pc, input fetch_pkg::word_t b_pc);
        trap_strobe     = do_trap;
        trap_pc         = t_pc;
        rollback_strobe = do_rollback;
        rollback_pc     = r_pc;
        branch_strobe   = do_branch;
        branch_target   = b_pc;
        @(negedge CLK);
        trap_strobe     = 1'b0;
        rollback_strobe = 1'b0;
        branch_strobe   = 1'b0;
    endtask

    // Update together with a branch two words before x
    task automatic train_btb(input fetch_pkg::word_t x, input fetch_pkg::word_t target,
                             input logic taken);
        btb_upd_strobe = 1'b1;
        btb_upd_pc     = x;
        btb_upd_target = target;
        btb_upd_taken  = taken;
        branch_strobe  = 1'b1;
        branch_target  = x - 32'd8;
        @(negedge CLK);
        btb_upd_strobe = 1'b0;
        branch_strobe  = 1'b0;
    endtask

    initial begin
        nRST            = 1'b0;
        ex_stall        = 1'b0;
        trap_strobe     = 1'b0;
        trap_pc         = '0;
        rollback_strobe = 1'b0;
        rollback_pc     = '0;
        branch_strobe   = 1'b0;
        branch_target   = '0;
        btb_upd_strobe  = 1'b0;
        btb_upd_pc      = '0;
        btb_upd_target  = '0;
        btb_upd_taken   = 1'b0;
        errors          = 0;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        // Straight line from the reset vector
        wait_insns(8);
        // Branch, trap beating branch, rollback
        redirect(1'b0, 1'b0, 1'b1, '0, '0, 32'h8000_0040);
        wait_insns(4);
        redirect(1'b1, 1'b0, 1'b1, 32'h8000_0100, '0, 32'h8000_0080);
        wait_insns(3);
        redirect(1'b0, 1'b1, 1'b0, '0, 32'h8000_0010, '0);
        wait_insns(3);
        // Taken entry at 0x48, then removed again
        train_btb(32'h8000_0048, 32'h8000_0180, 1'b1);
        wait_insns(6);
        train_btb(32'h8000_0048, '0, 1'b0);
        wait_insns(5);
        // Execute stall with a redirect inside it
        ex_stall = 1'b1;
        repeat (2) @(negedge CLK);
        redirect(1'b0, 1'b0, 1'b1, '0, '0, 32'h8000_0060);
        repeat (2) @(negedge CLK);
        ex_stall = 1'b0;
        wait_insns(3);
        // Misaligned stream
        redirect(1'b0, 1'b0, 1'b1, '0, '0, 32'h8000_0302);
        wait_insns(3);
        // Runs into the error window, parks, trap restarts
        redirect(1'b0, 1'b0, 1'b1, '0, '0, 32'h8000_01F8);
        wait_insns(3);
        repeat (8) @(negedge CLK);
        redirect(1'b1, 1'b0, 1'b0, 32'h8000_0020, '0, '0);
        wait_insns(4);
        repeat (4) @(negedge CLK);
        $display("Checked %0d instructions, %0d errors", seen, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (CYCLES_PER_INSN * PLANNED_INSNS) @(posedge CLK);
        $display("Timeout: the front end stopped delivering instructions");
        $display("Something failed");
        $finish;
    end

endmodule

// File: verification/fetch_imem_model.sv
// Behavioral instruction memory for the fetch front end testbench
// Address-keyed data, 0 to 3 random wait states, programmable bus error window

module fetch_imem_model (
    input  logic             CLK,
    input  logic             nRST,
    input  fetch_pkg::word_t addr,
    input  logic             ren,
    input  fetch_pkg::word_t err_lo,
    input  fetch_pkg::word_t err_hi,
    output fetch_pkg::word_t rdata,
    output logic             busy,
    output logic             error
);

    // Every address bit reaches the data word
    localparam fetch_pkg::word_t DATA_KEY = 32'h13579BDF;

    int               seed = 32'h1552_6938;
    logic             pending;
    fetch_pkg::word_t cur_addr;
    int unsigned      wait_left;
    int unsigned      next_wait;
    logic             fresh;

    // New access when idle or when the address moved
    assign fresh = !pending || (cur_addr != addr);
    assign busy  = ren && (fresh ? (next_wait != 0) : (wait_left != 0));
    assign rdata = addr ^ DATA_KEY;
    // Only looked at in the completing cycle
    assign error = ren && (addr >= err_lo) && (addr < err_hi);

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            pending   <= 1'b0;
            cur_addr  <= '0;
            wait_left <= 0;
            next_wait <= 0;
        end else if (!ren) begin
            pending <= 1'b0;
        end else if (fresh) begin
            // Wait count of the following access drawn up front
            next_wait <= {$random(seed)} % 4;
            pending   <= busy;
            cur_addr  <= addr;
            wait_left <= next_wait - 1;
        end else if (wait_left != 0) begin
            wait_left <= wait_left - 1;
        end else begin
            // Access completes this cycle
            pending <= 1'b0;
        end
    end

endmodule

// File: logic/fetch_frontend.sv
// Instruction fetch front end top level
// Connects the fetch stage, hazard unit and BTB predictor

module fetch_frontend (
    input  logic             CLK,
    input  logic             nRST,
    // Instruction bus
    input  fetch_pkg::word_t imem_rdata,
    input  logic             imem_busy,
    input  logic             imem_error,
    output fetch_pkg::word_t imem_addr,
    output logic             imem_ren,
    // Execute side
    input  logic             ex_stall,
    input  logic             trap_strobe,
    input  fetch_pkg::word_t trap_pc,
    input  logic             rollback_strobe,
    input  fetch_pkg::word_t rollback_pc,
    input  logic             branch_strobe,
    input  fetch_pkg::word_t branch_target,
    // BTB update
    input  logic             btb_upd_strobe,
    input  fetch_pkg::word_t btb_upd_pc,
    input  fetch_pkg::word_t btb_upd_target,
    input  logic             btb_upd_taken,
    // Fetch/execute register
    output logic             fe_valid,
    output fetch_pkg::word_t fe_instr,
    output fetch_pkg::word_t fe_pc,
    output fetch_pkg::word_t fe_pc4,
    output logic             fe_mal_insn,
    output logic             fe_fault_insn,
    output fetch_pkg::word_t fe_badaddr,
    output logic             fe_prediction
);

    // Predictor link
    fetch_pkg::word_t pc;
    logic             predict_taken;
    fetch_pkg::word_t predict_target;

    // Hazard link
    logic any_redirect;
    logic bus_busy;
    logic access_fault;
    logic pc_en;
    logic if_ex_stall;
    logic if_ex_flush;
    logic iren;

    fetch_stage i_stage (
        .CLK            (CLK),
        .nRST           (nRST),
        .imem_rdata     (imem_rdata),
        .imem_busy      (imem_busy),
        .imem_error     (imem_error),
        .imem_addr      (imem_addr),
        .imem_ren       (imem_ren),
        .trap_strobe    (trap_strobe),
        .rollback_strobe(rollback_strobe),
        .branch_strobe  (branch_strobe),
        .trap_pc        (trap_pc),
        .rollback_pc    (rollback_pc),
        .branch_target  (branch_target),
        .predict_taken  (predict_taken),
        .predict_target (predict_target),
        .pc             (pc),
        .pc_en          (pc_en),
        .if_ex_stall    (if_ex_stall),
        .if_ex_flush    (if_ex_flush),
        .iren           (iren),
        .any_redirect   (any_redirect),
        .bus_busy       (bus_busy),
        .access_fault   (access_fault),
        .fe_valid       (fe_valid),
        .fe_instr       (fe_instr),
        .fe_pc          (fe_pc),
        .fe_pc4         (fe_pc4),
        .fe_mal_insn    (fe_mal_insn),
        .fe_fault_insn  (fe_fault_insn),
        .fe_badaddr     (fe_badaddr),
        .fe_prediction  (fe_prediction)
    );

    fetch_hazard_unit i_hazard (
        .CLK         (CLK),
        .nRST        (nRST),
        .ex_stall    (ex_stall),
        .any_redirect(any_redirect),
        .bus_busy    (bus_busy),
        .access_fault(access_fault),
        .trap_strobe (trap_strobe),
        .pc_en       (pc_en),
        .if_ex_stall (if_ex_stall),
        .if_ex_flush (if_ex_flush),
        .iren        (iren)
    );

    btb_predictor i_btb (
        .CLK           (CLK),
        .nRST          (nRST),
        .pc            (pc),
        .predict_taken (predict_taken),
        .predict_target(predict_target),
        .btb_upd_strobe(btb_upd_strobe),
        .btb_upd_taken (btb_upd_taken),
        .btb_upd_pc    (btb_upd_pc),
        .btb_upd_target(btb_upd_target)
    );

endmodule

// File: logic/btb_predictor.sv
// Direct-mapped branch target buffer
// Combinational lookup on the fetch PC
// Synchronous update port from execute

module btb_predictor (
    input  logic             CLK,
    input  logic             nRST,
    // Lookup
    input  fetch_pkg::word_t pc,
    output logic             predict_taken,
    output fetch_pkg::word_t predict_target,
    // Update
    input  logic             btb_upd_strobe,
    input  logic             btb_upd_taken,
    input  fetch_pkg::word_t btb_upd_pc,
    input  fetch_pkg::word_t btb_upd_target
);

    localparam int IDX_LSB = fetch_pkg::PC_OFFSET_W;
    localparam int IDX_MSB = IDX_LSB + fetch_pkg::BTB_IDX_W - 1;
    localparam int TAG_LSB = IDX_MSB + 1;

    // Entry storage
    logic [fetch_pkg::BTB_ENTRIES-1:0] entry_valid;
    fetch_pkg::btb_tag_t               entry_tag    [fetch_pkg::BTB_ENTRIES];
    fetch_pkg::word_t                  entry_target [fetch_pkg::BTB_ENTRIES];

    // Lookup fields
    fetch_pkg::btb_idx_t rd_idx;
    fetch_pkg::btb_tag_t rd_tag;

    // Update fields
    fetch_pkg::btb_idx_t wr_idx;
    fetch_pkg::btb_tag_t wr_tag;
    logic                wr_tag_match;

    assign rd_idx = pc[IDX_MSB:IDX_LSB];
    assign rd_tag = pc[fetch_pkg::WORD_W-1:TAG_LSB];

    assign wr_idx = btb_upd_pc[IDX_MSB:IDX_LSB];
    assign wr_tag = btb_upd_pc[fetch_pkg::WORD_W-1:TAG_LSB];

    // Hit needs a valid entry and the full tag
    assign predict_taken  = entry_valid[rd_idx] && (entry_tag[rd_idx] == rd_tag);
    assign predict_target = entry_target[rd_idx];

    // A not-taken update only evicts its own branch, not an alias
    assign wr_tag_match = entry_valid[wr_idx] && (entry_tag[wr_idx] == wr_tag);

    // Valid bits
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            entry_valid <= '0;
        end else if (btb_upd_strobe) begin
            if (btb_upd_taken) begin
                entry_valid[wr_idx] <= 1'b1;
            end else if (wr_tag_match) begin
                entry_valid[wr_idx] <= 1'b0;
            end
        end
    end

    // Tag and target arrays
    // Taken update overwrites whatever sat in the slot
    always_ff @(posedge CLK) begin
        if (btb_upd_strobe && btb_upd_taken) begin
            entry_tag[wr_idx]    <= wr_tag;
            entry_target[wr_idx] <= btb_upd_target;
        end
    end

endmodule

// File: logic/fetch_hazard_unit.sv
// Fetch hazard unit
// PC enable, fetch/execute stall and flush, bus read enable
// Fault-wait FSM that parks fetch after a bus error until the trap redirect

module fetch_hazard_unit (
    input  logic CLK,
    input  logic nRST,
    input  logic ex_stall,
    input  logic any_redirect,
    input  logic bus_busy,
    input  logic access_fault,
    input  logic trap_strobe,
    output logic pc_en,
    output logic if_ex_stall,
    output logic if_ex_flush,
    output logic iren
);

    fetch_pkg::fetch_state_t state;
    fetch_pkg::fetch_state_t state_next;
    logic                    fault_wait;
    logic                    fault_taken;

    assign fault_wait = (state == fetch_pkg::FETCH_FAULT_WAIT);

    // Fault only counts when the faulting word actually enters the register
    // A redirect in the same cycle discards it
    assign fault_taken = access_fault & ~ex_stall & ~any_redirect;

    // State register
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= fetch_pkg::FETCH_RUN;
        end else begin
            state <= state_next;
        end
    end

    // Next state
    always_comb begin
        state_next = state;
        case (state)
            fetch_pkg::FETCH_RUN: begin
                if (fault_taken) begin
                    state_next = fetch_pkg::FETCH_FAULT_WAIT;
                end
            end
            fetch_pkg::FETCH_FAULT_WAIT: begin
                // Only the trap entry releases the front end
                if (trap_strobe) begin
                    state_next = fetch_pkg::FETCH_RUN;
                end
            end
            default: state_next = fetch_pkg::FETCH_RUN;
        endcase
    end

    // While parked the PC moves only for the trap and no reads go out
    // Otherwise a redirect or a completed access advances the PC
    assign pc_en = fault_wait ? trap_strobe : (any_redirect | (~bus_busy & ~ex_stall));
    assign iren  = ~fault_wait;

    // Bubbles on redirect, on an access in flight and while parked
    assign if_ex_flush = any_redirect | bus_busy | fault_wait;
    assign if_ex_stall = ex_stall;

endmodule

// File: logic/fetch_stage.sv
// PC register, next-PC priority select and instruction bus request
// Misaligned fetch and bus error detection
// Fetch/execute pipeline register with the fe_ outputs

module fetch_stage (
    input  logic            CLK,
    input  logic            nRST,
    // Instruction bus
    input  fetch_pkg::word_t imem_rdata,
    input  logic            imem_busy,
    input  logic            imem_error,
    output fetch_pkg::word_t imem_addr,
    output logic            imem_ren,
    // Redirects from execute
    input  logic            trap_strobe,
    input  logic            rollback_strobe,
    input  logic            branch_strobe,
    input  fetch_pkg::word_t trap_pc,
    input  fetch_pkg::word_t rollback_pc,
    input  fetch_pkg::word_t branch_target,
    // Predictor
    input  logic            predict_taken,
    input  fetch_pkg::word_t predict_target,
    output fetch_pkg::word_t pc,
    // Hazard unit
    input  logic            pc_en,
    input  logic            if_ex_stall,
    input  logic            if_ex_flush,
    input  logic            iren,
    output logic            any_redirect,
    output logic            bus_busy,
    output logic            access_fault,
    // Fetch/execute register
    output logic            fe_valid,
    output fetch_pkg::word_t fe_instr,
    output fetch_pkg::word_t fe_pc,
    output fetch_pkg::word_t fe_pc4,
    output logic            fe_mal_insn,
    output logic            fe_fault_insn,
    output fetch_pkg::word_t fe_badaddr,
    output logic            fe_prediction
);

    fetch_pkg::word_t pc4;
    fetch_pkg::word_t npc;
    logic             mal_addr;
    logic             squash;
    logic             fe_load;

    // PC register
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc <= fetch_pkg::RESET_PC;
        end else if (pc_en) begin
            pc <= npc;
        end
    end

    assign pc4 = pc + 32'd4;

    // Fixed priority of trap, rollback, branch, prediction and pc + 4
    always_comb begin
        if (trap_strobe) begin
            npc = trap_pc;
        end else if (rollback_strobe) begin
            npc = rollback_pc;
        end else if (branch_strobe) begin
            npc = branch_target;
        end else if (predict_taken) begin
            npc = predict_target;
        end else begin
            npc = pc4;
        end
    end

    assign any_redirect = trap_strobe | rollback_strobe | branch_strobe;

    // Bus request
    // No read goes out for a misaligned PC
    assign mal_addr  = (pc[1:0] != 2'b00);
    assign imem_addr = pc;
    assign imem_ren  = iren & ~mal_addr;

    // Busy only counts while a read is actually requested
    assign bus_busy = imem_ren & imem_busy;

    // Error is only valid in the completing cycle
    assign access_fault = imem_ren & ~imem_busy & imem_error;

    // Either exception squashes the instruction word
    assign squash = mal_addr | access_fault;

    // Register takes a new instruction when neither stalled nor flushed
    assign fe_load = ~if_ex_stall & ~if_ex_flush;

    // Control flags of the fetch/execute register
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            fe_valid      <= 1'b0;
            fe_mal_insn   <= 1'b0;
            fe_fault_insn <= 1'b0;
            fe_prediction <= 1'b0;
        end else if (!if_ex_stall) begin
            if (if_ex_flush) begin
                // Bubble
                fe_valid      <= 1'b0;
                fe_mal_insn   <= 1'b0;
                fe_fault_insn <= 1'b0;
                fe_prediction <= 1'b0;
            end else begin
                // Stays valid on exceptions so execute can trap
                fe_valid      <= 1'b1;
                fe_mal_insn   <= mal_addr;
                fe_fault_insn <= access_fault;
                fe_prediction <= predict_taken;
            end
        end
    end

    // Payload of the fetch/execute register
    always_ff @(posedge CLK) begin
        if (fe_load) begin
            fe_instr   <= squash ? '0 : imem_rdata;
            fe_pc      <= pc;
            fe_pc4     <= pc4;
            fe_badaddr <= imem_addr;
        end
    end

endmodule

// File: logic/fetch_pkg.sv
// Shared definitions for the instruction fetch front end
// Word type, reset vector, BTB geometry and the fault-wait state encoding

package fetch_pkg;

    // Datapath width
    localparam int WORD_W = 32;

    // Instructions, PCs and bus data all share one word type
    typedef logic [WORD_W-1:0] word_t;

    // First fetch address after reset
    localparam word_t RESET_PC = 32'h80000000;

    // Byte offset of a word inside the PC
    localparam int PC_OFFSET_W = 2;

    // Direct-mapped BTB geometry
    localparam int BTB_ENTRIES = 16;
    localparam int BTB_IDX_W = 4;

    // Tag covers every PC bit above the index
    localparam int BTB_TAG_W = WORD_W - BTB_IDX_W - PC_OFFSET_W;

    // BTB index from PC bits 5..2
    typedef logic [BTB_IDX_W-1:0] btb_idx_t;

    // BTB tag from PC bits 31..6
    typedef logic [BTB_TAG_W-1:0] btb_tag_t;

    // Hazard unit states
    // FETCH_FAULT_WAIT parks the front end after a bus error
    typedef enum logic {
        FETCH_RUN,
        FETCH_FAULT_WAIT
    } fetch_state_t;

endpackage
